//--- src.f
sbox_pkg.sv
sub_ctrl_if.sv
power_map_sbox.sv
word_rotate_reg.sv
step_counter.sv
sub_layer_fsm.sv
sub_layer_top.sv
tb_sub_layer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sub_layer
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Everything OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_sub_layer.sv
`timescale 1ns/10ps
`default_nettype none

module tb_sub_layer import sbox_pkg::*; ();

  localparam int N     = 6;
  localparam int BLK_W = N * WORD_W;

  // basis change columns per input bit with bit 5 first
  localparam logic [35:0] FWD_COLS = {6'b111010, 6'b011000, 6'b000001,
                                      6'b101101, 6'b000110, 6'b111111};
  localparam logic [35:0] INV_COLS = {6'b011011, 6'b101110, 6'b111110,
                                      6'b101001, 6'b101011, 6'b001000};

  logic             clk;
  logic             reset;
  logic             start;
  logic [BLK_W-1:0] block_in;
  logic [BLK_W-1:0] block_out;
  logic             busy;
  logic             done;

  int               seed = 84;
  int               runs = 0;
  int               done_count = 0;
  int               in_count = 0;      // distinct word values swept
  logic             in_flight;         // a block was accepted and is not finished
  int               age;               // edges since the accepted start
  logic             started;
  logic [BLK_W-1:0] exp_block;
  logic [BLK_W-1:0] cur_in;
  logic             in_sweep = 1'b0;
  logic             repeat_out = 1'b0;
  logic             zero_bad = 1'b0;
  logic             one_bad = 1'b0;
  logic             in_seen [64] = '{default: 1'b0};
  logic             out_seen [64] = '{default: 1'b0};

  sub_layer_top #(.NUM_WORDS(N)) u_dut (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .block_in  (block_in),
    .block_out (block_out),
    .busy      (busy),
    .done      (done)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // GF(4) product through discrete logs with 1 = 11, t = 01 and t^2 = 10
  function automatic logic [1:0] gf4_log_mul(input logic [1:0] a, input logic [1:0] b);
    int s;
    if (a == 2'b00 || b == 2'b00) begin
      return 2'b00;
    end
    s = ((a == 2'b11) ? 0 : (a == 2'b01) ? 1 : 2)
        + ((b == 2'b11) ? 0 : (b == 2'b01) ? 1 : 2);
    case (s % 3)
      0: return 2'b11;
      1: return 2'b01;
      default: return 2'b10;
    endcase
  endfunction

  function automatic logic [5:0] sbox_model(input logic [5:0] v);
    logic [5:0] w;
    logic [5:0] p;
    logic [5:0] r;
    logic [1:0] a, b, c;
    logic [1:0] ma, mb, mc;  // all ones where the limb is nonzero
    logic [1:0] a2, b2, c2;
    w = '0;
    for (int k = 0; k < 6; k++) begin
      if (v[k]) w = w ^ FWD_COLS[k*6 +: 6];
    end
    a = w[1:0];
    b = w[3:2];
    c = w[5:4];
    ma = {2{a != 2'b00}};
    mb = {2{b != 2'b00}};
    mc = {2{c != 2'b00}};
    a2 = gf4_log_mul(a, a);
    b2 = gf4_log_mul(b, b);
    c2 = gf4_log_mul(c, c);
    p[1:0] = a ^ b ^ (mb & a) ^ (mb & c) ^ (mc & a) ^ gf4_log_mul(a2, b2) ^ gf4_log_mul(a2, c2)
             ^ gf4_log_mul(a2, gf4_log_mul(b, c)) ^ gf4_log_mul(c2, gf4_log_mul(a, b));
    p[3:2] = b ^ c ^ (ma & b) ^ (mc & a) ^ (mc & b) ^ gf4_log_mul(a2, b2) ^ gf4_log_mul(b2, c2)
             ^ gf4_log_mul(a2, gf4_log_mul(b, c)) ^ gf4_log_mul(b2, gf4_log_mul(a, c));
    p[5:4] = a ^ c ^ (ma & b) ^ (ma & c) ^ (mb & c) ^ gf4_log_mul(a2, c2) ^ gf4_log_mul(b2, c2)
             ^ gf4_log_mul(b2, gf4_log_mul(a, c)) ^ gf4_log_mul(c2, gf4_log_mul(a, b));
    r = '0;
    for (int k = 0; k < 6; k++) begin
      if (p[k]) r = r ^ INV_COLS[k*6 +: 6];
    end
    return r;
  endfunction

  function automatic logic [BLK_W-1:0] block_model(input logic [BLK_W-1:0] blk);
    logic [BLK_W-1:0] res;
    for (int i = 0; i < N; i++) begin
      res[i*WORD_W +: WORD_W] = sbox_model(blk[i*WORD_W +: WORD_W]);
    end
    return res;
  endfunction

  function automatic logic [BLK_W-1:0] random_block();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[BLK_W-1:0];
  endfunction

  task automatic halt_failed();
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic mismatch_seen(input string what);
    $display("Mismatch at %0t ns: %s", $time, what);
    halt_failed();
  endtask

  task automatic waited_too_long(input string what);
    $display("Timed out at %0t ns waiting for %s", $time, what);
    halt_failed();
  endtask

  // start counts only outside a run and its done cycle
  always @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
      age       <= 0;
      started   <= 1'b0;
      exp_block <= '0;
    end else if (in_flight) begin
      age <= age + 1;
      if (age == N + 1) begin
        in_flight <= 1'b0;
      end
    end else if (start) begin
      in_flight <= 1'b1;
      age       <= 0;
      started   <= 1'b1;
      exp_block <= block_model(block_in);
      cur_in    <= block_in;
    end
  end

  always @(posedge clk) begin
    logic       rep;
    logic       zb;
    logic       ob;
    logic [5:0] wi;
    logic [5:0] wo;
    rep = 1'b0;
    zb  = 1'b0;
    ob  = 1'b0;
    if (!reset && done) begin
      done_count = done_count + 1;
      for (int i = 0; i < N && in_sweep; i++) begin
        wi = cur_in[i*WORD_W +: WORD_W];
        wo = block_out[i*WORD_W +: WORD_W];
        if (!in_seen[wi]) begin
          in_seen[wi] = 1'b1;
          in_count    = in_count + 1;
          rep         = rep | out_seen[wo];
          out_seen[wo] = 1'b1;
        end
        if (wi == 6'd0 && wo != 6'd0) zb = 1'b1;
        if (wi == 6'd1 && wo != 6'd1) ob = 1'b1;
      end
    end
    repeat_out <= repeat_out | rep;
    zero_bad   <= zero_bad | zb;
    one_bad    <= one_bad | ob;
  end

  a_idle: assert property (@(posedge clk) disable iff (reset)
    !started |-> (!done && !busy && block_out == '0))
    else mismatch_seen("outputs not quiet before the first start");
  a_done: assert property (@(posedge clk) disable iff (reset)
    done == (in_flight && age == N + 1))
    else mismatch_seen("done not a single pulse N+1 cycles after the accepted start");
  a_busy: assert property (@(posedge clk) disable iff (reset)
    busy == (in_flight && age <= N))
    else mismatch_seen("busy outside the run window");
  a_result: assert property (@(posedge clk) disable iff (reset)
    done |-> block_out == exp_block)
    else mismatch_seen($sformatf("block_out %h, expected %h", $sampled(block_out),
                                 $sampled(exp_block)));
  a_hold: assert property (@(posedge clk) disable iff (reset)
    (started && !in_flight) |-> block_out == exp_block)
    else mismatch_seen("block_out changed after done");
  a_zero: assert property (@(posedge clk) !zero_bad)
    else mismatch_seen("word 0 not mapped to 0");
  a_one: assert property (@(posedge clk) !one_bad)
    else mismatch_seen("word 1 not mapped to 1");
  a_perm: assert property (@(posedge clk) !repeat_out)
    else mismatch_seen("two word values share one output value");

  task automatic pulse_start(input logic [BLK_W-1:0] data);
    @(posedge clk);
    #1;
    start    = 1'b1;
    block_in = data;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (done !== 1'b1) begin
      @(posedge clk);
      #1;
      n = n + 1;
      if (n > 4 * N) waited_too_long("done");
    end
  endtask

  task automatic run_block(input logic [BLK_W-1:0] data);
    pulse_start(data);
    wait_done();
    runs = runs + 1;
  endtask

  initial begin
    logic [BLK_W-1:0] blk;
    start    = 1'b0;
    block_in = '0;
    reset    = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    repeat (5) @(posedge clk);  // outputs stay at reset values while idle

    in_sweep = 1'b1;  // 11 blocks cover all 64 word values
    for (int k = 0; k < 11; k++) begin
      for (int i = 0; i < N; i++) begin
        blk[i*WORD_W +: WORD_W] = 6'((k * N + i) % 64);
      end
      run_block(blk);
    end
    @(posedge clk);
    #1;
    in_sweep = 1'b0;

    for (int j = 0; j < 20; j++) begin
      run_block(random_block());
      block_in = random_block();  // moves while the result must hold
      repeat (j % 3) @(posedge clk);
    end

    // starts during the run and in the done cycle
    pulse_start(random_block());
    for (int j = 0; j < 2; j++) begin
      @(posedge clk);
      #1;
      start    = 1'b1;
      block_in = random_block();
      @(posedge clk);
      #1;
      start = 1'b0;
    end
    wait_done();
    runs     = runs + 1;
    start    = 1'b1;
    block_in = random_block();
    @(posedge clk);
    #1;
    start = 1'b0;
    repeat (4) @(posedge clk);

    run_block(random_block());
    run_block(random_block());  // start in the cycle right after done
    repeat (4) @(posedge clk);

    if (done_count == runs && in_count == 64) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Run incomplete: %0d of %0d blocks finished, %0d of 64 word values swept",
               done_count, runs, in_count);
      halt_failed();
    end
  end

endmodule

`default_nettype wire

//--- sub_layer_top.sv
`timescale 1ns/10ps
`default_nettype none

module sub_layer_top import sbox_pkg::*; #(
  parameter int NUM_WORDS = 6
) (
  input  wire logic                        clk,
  input  wire logic                        reset,
  input  wire logic                        start,
  input  wire logic [NUM_WORDS*WORD_W-1:0] block_in,
  output logic      [NUM_WORDS*WORD_W-1:0] block_out,
  output logic                             busy,
  output logic                             done
);

  sub_ctrl_if ctrl ();

  sbox_word_u sbox_in;   // word 0 of the block
  sbox_word_u sbox_out;  // its substitute

  sub_layer_fsm u_fsm (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .ctrl  (ctrl.fsm),
    .busy  (busy),
    .done  (done)
  );

  step_counter #(.NUM_WORDS(NUM_WORDS)) u_cnt (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl.cnt)
  );

  word_rotate_reg #(.NUM_WORDS(NUM_WORDS)) u_blk (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl.dp),
    .block_in  (block_in),
    .sbox_in   (sbox_in),
    .sbox_out  (sbox_out),
    .block_out (block_out)
  );

  power_map_sbox u_sbox (
    .x (sbox_in),
    .y (sbox_out)
  );

endmodule

`default_nettype wire

//--- sub_layer_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module sub_layer_fsm (
  input  wire logic clk,
  input  wire logic reset,
  input  wire logic start,
  sub_ctrl_if.fsm   ctrl,
  output logic      busy,
  output logic      done
);

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_RUN    = 2'd1;
  localparam logic [1:0] ST_FINISH = 2'd2;

  logic [1:0] state;
  logic       accept;

  // start counts only when idle and not in the done cycle
  assign accept = (state == ST_IDLE) && start && !done;

  // block and counter take the start edge itself
  assign ctrl.load  = accept;
  assign ctrl.clear = accept;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      ctrl.step <= 1'b0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (accept) begin
            state     <= ST_RUN;
            ctrl.step <= 1'b1;
          end
        end
        ST_RUN: begin
          if (ctrl.last) begin  // final word substituted on this edge
            state     <= ST_FINISH;
            ctrl.step <= 1'b0;
          end
        end
        ST_FINISH: begin
          state <= ST_IDLE;
          done  <= 1'b1;
        end
        default: begin
          state     <= ST_IDLE;
          ctrl.step <= 1'b0;
        end
      endcase
    end
  end

  assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

//--- step_counter.sv
`timescale 1ns/10ps
`default_nettype none

module step_counter #(
  parameter int NUM_WORDS = 6
) (
  input  wire logic clk,
  input  wire logic reset,
  sub_ctrl_if.cnt   ctrl
);

  localparam int CNT_W = (NUM_WORDS > 2) ? $clog2(NUM_WORDS) : 1;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(NUM_WORDS - 1);

  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ctrl.clear) begin
      count <= '0;
    end else if (ctrl.step) begin
      count <= count + 1'b1;
    end
  end

  // count holds the number of steps already done
  assign ctrl.last = ctrl.step && (count == LAST_CNT);

endmodule

`default_nettype wire

//--- word_rotate_reg.sv
`timescale 1ns/10ps
`default_nettype none

module word_rotate_reg import sbox_pkg::*; #(
  parameter int NUM_WORDS = 6
) (
  input  wire logic                          clk,
  input  wire logic                          reset,
  sub_ctrl_if.dp                             ctrl,
  input  wire logic [NUM_WORDS*WORD_W-1:0]   block_in,
  output sbox_word_u                         sbox_in,
  input  wire sbox_word_u                    sbox_out,
  output logic      [NUM_WORDS*WORD_W-1:0]   block_out
);

  localparam int BLK_W = NUM_WORDS * WORD_W;

  logic [BLK_W-1:0] blk;

  // word 0 always feeds the S-box
  assign sbox_in.bits = blk[WORD_W-1:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      blk <= '0;
    end else if (ctrl.load) begin
      blk <= block_in;
    end else if (ctrl.step) begin
      // shift down one word and put the substituted word at the top
      blk <= {sbox_out.bits, blk[BLK_W-1:WORD_W]};
    end
  end

  assign block_out = blk;  // back in place after NUM_WORDS steps

endmodule

`default_nettype wire

//--- power_map_sbox.sv
`timescale 1ns/10ps
`default_nettype none

module power_map_sbox import sbox_pkg::*; (
  input  wire sbox_word_u x,
  output sbox_word_u      y
);

  sbox_word_u w;  // tower basis input
  sbox_word_u p;  // tower basis result

  gf4_t x0, x1, x2;
  gf4_t y0, y1, y2, y3, y4, y5;
  gf4_t x3, x4, x5, x6, x7, x8;
  gf4_t x9, x10, x11, x12, x13, x14;

  // into the tower over GF(4)
  always_comb begin
    w.bits[0] = x.bits[0] ^ x.bits[2] ^ x.bits[3];
    w.bits[1] = x.bits[0] ^ x.bits[1] ^ x.bits[5];
    w.bits[2] = x.bits[0] ^ x.bits[1] ^ x.bits[2];
    w.bits[3] = x.bits[0] ^ x.bits[2] ^ x.bits[4] ^ x.bits[5];
    w.bits[4] = x.bits[0] ^ x.bits[4] ^ x.bits[5];
    w.bits[5] = x.bits[0] ^ x.bits[2] ^ x.bits[5];
  end

  assign x0 = w.limbs.limb0;
  assign x1 = w.limbs.limb1;
  assign x2 = w.limbs.limb2;

  assign y0 = gf4_sq(x0);
  assign y1 = gf4_sq(x1);
  assign y2 = gf4_sq(x2);

  assign x3 = gf4_cube_mul(x0, x1);
  assign x4 = gf4_cube_mul(x0, x2);
  assign x5 = gf4_cube_mul(x1, x0);
  assign x6 = gf4_cube_mul(x1, x2);
  assign x7 = gf4_cube_mul(x2, x0);
  assign x8 = gf4_cube_mul(x2, x1);

  assign x9  = gf4_mul(y0, y1);
  assign x10 = gf4_mul(y0, y2);
  assign x11 = gf4_mul(y1, y2);

  // cross products of a squared limb with the other two
  assign y3  = gf4_mul(x1, x2);
  assign x12 = gf4_mul(y0, y3);
  assign y4  = gf4_mul(x0, x2);
  assign x13 = gf4_mul(y1, y4);
  assign y5  = gf4_mul(x0, x1);
  assign x14 = gf4_mul(y2, y5);

  assign p.limbs.limb0 = gf4_add(gf4_add(gf4_add(gf4_add(x0, x1), gf4_add(x5, x6)),
                                         gf4_add(gf4_add(x7, x9), gf4_add(x10, x12))), x14);
  assign p.limbs.limb1 = gf4_add(gf4_add(gf4_add(gf4_add(x1, x2), gf4_add(x3, x7)),
                                         gf4_add(gf4_add(x8, x9), gf4_add(x11, x12))), x13);
  assign p.limbs.limb2 = gf4_add(gf4_add(gf4_add(gf4_add(x0, x2), gf4_add(x3, x4)),
                                         gf4_add(gf4_add(x6, x10), gf4_add(x11, x13))), x14);

  // back to the polynomial basis
  always_comb begin
    y.bits[0] = p.bits[1] ^ p.bits[2] ^ p.bits[5];
    y.bits[1] = p.bits[1] ^ p.bits[3] ^ p.bits[4] ^ p.bits[5];
    y.bits[2] = p.bits[3] ^ p.bits[4];
    y.bits[3] = p.bits[0] ^ p.bits[1] ^ p.bits[2] ^ p.bits[3] ^ p.bits[4] ^ p.bits[5];
    y.bits[4] = p.bits[3] ^ p.bits[5];
    y.bits[5] = p.bits[1] ^ p.bits[2] ^ p.bits[3] ^ p.bits[4];
  end

endmodule

`default_nettype wire

//--- sub_ctrl_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sub_ctrl_if;

  logic load;   // capture block_in
  logic step;   // one substitution this cycle
  logic clear;  // restart step count
  logic last;   // current step is the final one

  modport fsm (
    output load,
    output step,
    output clear,
    input  last
  );

  modport cnt (
    input  step,
    input  clear,
    output last
  );

  modport dp (
    input load,
    input step
  );

endinterface

`default_nettype wire

//--- sbox_pkg.sv
`default_nettype none

package sbox_pkg;

  parameter int WORD_W = 6;

  // one GF(4) element in normal basis
  typedef logic [1:0] gf4_t;

  typedef struct packed {
    gf4_t limb2;
    gf4_t limb1;
    gf4_t limb0;
  } sbox_limbs_t;

  // same 6 bits seen flat or as three tower limbs
  typedef union packed {
    logic [WORD_W-1:0] bits;
    sbox_limbs_t       limbs;
  } sbox_word_u;

  // squaring swaps the two normal-basis coordinates
  function automatic gf4_t gf4_sq(input gf4_t a);
    return {a[0], a[1]};
  endfunction

  function automatic gf4_t gf4_add(input gf4_t a, input gf4_t b);
    return a ^ b;
  endfunction

  function automatic gf4_t gf4_mul(input gf4_t a, input gf4_t b);
    logic t;
    t = (a[0] & b[1]) ^ (a[1] & b[0]);
    return {(a[0] & b[0]) ^ t, (a[1] & b[1]) ^ t};
  endfunction

  // a^3 * b with a^3 = 1 for any nonzero a
  function automatic gf4_t gf4_cube_mul(input gf4_t a, input gf4_t b);
    logic t;
    t = a[0] ^ (~a[0] & a[1]);
    return {t & b[1], t & b[0]};
  endfunction

endpackage

`default_nettype wire
